/* bench/bbc_glue_patterns.txt */
# op model phi0 addr data exp1 exp2 exp3, all hex
# W: romsel acccon {irq,vid}  R: cpu_di shadow mem_we  S: shadow  L: ic32  V: mem_adr  C: sel mem_adr mem_we  X: cpu_di
C 0 1 0000 1 400 0000 0
C 0 1 7FFF 0 400 7FFF 1
C 1 1 8000 1 200 8000 0
C 1 1 C000 1 100 C000 0
C 0 1 FBFF 1 100 FBFF 0
C 1 1 FC10 1 080 FC10 0
C 0 1 FD00 1 040 FD00 0
C 1 1 FE00 1 030 FE00 0
C 0 1 FE08 1 020 FE08 0
C 0 1 FE30 1 028 FE30 0
C 0 1 FE34 1 028 FE34 0
C 1 1 FE34 1 024 FE34 0
C 1 1 FE38 1 020 FE38 0
C 0 1 FE3C 1 028 FE3C 0
C 1 1 FE40 1 022 FE40 0
C 0 1 FE60 1 021 FE60 0
C 1 1 FF00 1 100 FF00 0
C 1 0 FE30 0 028 0000 0
W 0 1 FE34 FF 7F 00 0
W 0 1 FE30 8F 0F 00 0
R 0 1 FE30 55 00 0 0
W 1 1 FE30 8F 8F 00 0
R 1 1 FE30 55 8F 0 0
W 1 1 FE34 81 8F 81 3
R 1 1 FE34 00 81 0 0
W 1 1 FE34 04 8F 04 0
R 1 1 3000 11 11 1 0
R 1 1 7FFF 22 22 1 0
R 1 1 2FFF 33 33 0 0
R 1 1 8000 44 44 0 0
W 1 1 FE34 02 8F 02 0
S 1 1 C000 00 0 0 0
R 1 1 3000 11 11 1 0
S 1 1 3000 00 0 0 0
R 1 1 5000 66 66 0 0
S 1 1 DFFF 00 0 0 0
R 1 1 7000 77 77 1 0
S 1 1 E000 00 0 0 0
R 1 1 7000 77 77 0 0
L 1 0 0000 04 00 0 0
L 1 0 0000 05 00 0 0
V 1 0 1234 1D 51A5 0 0
V 1 0 0234 05 11A5 0 0
V 1 0 23FF 00 3FFF 0 0
L 1 0 0000 0C 10 0 0
V 1 0 1F00 07 5807 0 0
L 1 0 0000 04 00 0 0
L 1 0 0000 0D 20 0 0
V 1 0 1A80 02 0402 0 0
L 1 0 0000 0C 30 0 0
V 1 0 1510 03 0083 0 0
V 1 0 1100 00 6000 0 0
V 1 0 3400 00 7C00 0 0
L 1 0 0000 0F B0 0 0
L 1 0 0000 08 B1 0 0
X 1 1 0100 5A 5A 0 0
R 1 1 FE34 00 00 0 0
C 0 1 7FFF 0 400 7FFF 1

/* compile.f */
design/bbc_glue_pkg.sv
design/address_decode.sv
design/system_latches.sv
design/display_addr_xlate.sv
design/bus_result.sv
design/bbc_glue.sv
bench/bbc_glue_chk.sv
bench/tb_bbc_glue.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_bbc_glue
RTL_TOP   ?= bbc_glue
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

RTL_SRCS ?= design/bbc_glue_pkg.sv design/address_decode.sv design/system_latches.sv \
	design/display_addr_xlate.sv design/bus_result.sv design/bbc_glue.sv

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "TESTS FAILED" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "TESTS PASSED" $(LOG); then echo "Simulation did not complete"; exit 1; fi

lint:
	$(VERILATOR) --lint-only $(RTL_SRCS) --top-module $(RTL_TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* bench/tb_bbc_glue.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_bbc_glue;

	import bbc_glue_pkg::*;

	localparam int    CLK_PERIOD   = 8;
	localparam int    RESET_CYCLES = 16;
	localparam int    MAX_RECORDS  = 200;
	localparam int    CLEAR_WAIT   = 4;
	localparam string PATTERN_FILE = "bench/bbc_glue_patterns.txt";

	logic       CLK48M_I;
	logic       reset_n;
	logic       cpu_clken;
	logic       phi0;
	logic       model;
	cpu_bus_t   cpu;
	crtc_addr_t crtc;
	logic [7:0] via_pb;
	logic [7:0] mem_di;

	logic [7:0]  cpu_di;
	dev_sel_t    sel;
	logic [7:0]  romsel;
	acccon_t     acccon;
	ic32_t       ic32;
	logic        shadow_ram;
	logic        shadow_vid;
	logic        irq;
	logic [15:0] mem_adr;
	logic        mem_we;

	int check_count;
	int mismatch_count;
	int other_errors;

	bbc_glue u_bbc_glue (
		.CLK48M_I     (CLK48M_I),
		.reset_n      (reset_n),
		.cpu_clken_i  (cpu_clken),
		.phi0_i       (phi0),
		.model_i      (model),
		.cpu_i        (cpu),
		.crtc_i       (crtc),
		.via_pb_i     (via_pb),
		.mem_di_i     (mem_di),
		.cpu_di_o     (cpu_di),
		.sel_o        (sel),
		.romsel_o     (romsel),
		.acccon_o     (acccon),
		.ic32_o       (ic32),
		.shadow_ram_o (shadow_ram),
		.shadow_vid_o (shadow_vid),
		.irq_o        (irq),
		.mem_adr_o    (mem_adr),
		.mem_we_o     (mem_we)
	);

	initial begin
		CLK48M_I = 1'b0;
		forever #(CLK_PERIOD / 2) CLK48M_I = ~CLK48M_I;
	end

	// Guard against a run that never reaches the report
	initial begin
		#(CLK_PERIOD * 20000);
		$display("Timeout: the pattern run did not finish in time");
		$display("TESTS FAILED");
		$finish;
	end

	task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
		check_count++;
		if (got !== exp) begin
			mismatch_count++;
			$display("MISMATCH %0t %s: got %0h expected %0h", $time, what, got, exp);
		end
	endtask

	// Quarter period after the falling edge, inputs have settled
	task automatic settle;
		#(CLK_PERIOD / 4);
	endtask

	task automatic apply_reset;
		int waited;
		reset_n = 1'b0;
		for (int i = 0; i < RESET_CYCLES; i++) begin
			@(negedge CLK48M_I);
		end
		reset_n = 1'b1;
		waited = 0;
		while ((romsel !== 8'h00 || acccon !== 8'h00 || ic32 !== 8'h00) &&
			waited < CLEAR_WAIT) begin
			@(negedge CLK48M_I);
			waited++;
		end
		if (waited >= CLEAR_WAIT) begin
			other_errors++;
			$display("Registers did not clear after reset within %0d cycles", CLEAR_WAIT);
		end
		check_eq(32'(romsel), 32'h0, "romsel after reset");
		check_eq(32'(acccon), 32'h0, "acccon after reset");
		check_eq(32'(ic32), 32'h0, "ic32 after reset");
	endtask

	task automatic run_record(input byte op, input logic [31:0] f_model, input logic [31:0] f_phi0,
		input logic [31:0] f_addr, input logic [31:0] f_data, input logic [31:0] e1,
		input logic [31:0] e2, input logic [31:0] e3);
		model     = f_model[0];
		phi0      = f_phi0[0];
		cpu.addr  = f_addr[15:0];
		cpu.wdata = f_data[7:0];
		cpu.r_nw  = 1'b1;
		cpu.sync  = 1'b0;
		case (op)
			"W": begin
				cpu.r_nw  = 1'b0;
				cpu_clken = 1'b1;
				@(negedge CLK48M_I);
				cpu_clken = 1'b0;
				cpu.r_nw  = 1'b1;
				check_eq(32'(romsel), e1, "romsel after write");
				check_eq(32'(acccon), e2, "acccon after write");
				check_eq(32'({irq, shadow_vid}), e3, "irq and shadow_vid");
			end
			"R": begin
				mem_di = f_data[7:0];
				settle();
				check_eq(32'(cpu_di), e1, "read data");
				check_eq(32'(shadow_ram), e2, "shadow ram");
				check_eq(32'(mem_we), e3, "write strobe on read");
				@(negedge CLK48M_I);
			end
			"S": begin
				cpu.sync  = 1'b1;
				cpu_clken = 1'b1;
				settle();
				check_eq(32'(shadow_ram), e1, "shadow ram during sync");
				@(negedge CLK48M_I);
				cpu_clken = 1'b0;
				cpu.sync  = 1'b0;
			end
			"L": begin
				via_pb = f_data[7:0];
				@(negedge CLK48M_I);
				check_eq(32'(ic32), e1, "ic32 latch");
			end
			"V": begin
				crtc.ma = f_addr[13:0];
				crtc.ra = f_data[4:0];
				settle();
				check_eq(32'(mem_adr), e1, "video memory address");
				@(negedge CLK48M_I);
			end
			"C": begin
				cpu.r_nw = f_data[0];
				settle();
				check_eq(32'(sel), e1, "device selects");
				check_eq(32'(mem_adr), e2, "memory address");
				check_eq(32'(mem_we), e3, "memory write strobe");
				@(negedge CLK48M_I);
				cpu.r_nw = 1'b1;
			end
			"X": begin
				via_pb = 8'h00;
				apply_reset();
				mem_di = f_data[7:0];
				settle();
				check_eq(32'(cpu_di), e1, "memory read after reset");
				@(negedge CLK48M_I);
			end
			default: begin
				other_errors++;
				$display("Unknown op code '%c' in the pattern file", op);
			end
		endcase
	endtask

	initial begin
		int          fd;
		int          code;
		int          fields;
		int          records;
		string       line;
		byte         op;
		logic [31:0] f_model;
		logic [31:0] f_phi0;
		logic [31:0] f_addr;
		logic [31:0] f_data;
		logic [31:0] e1;
		logic [31:0] e2;
		logic [31:0] e3;

		check_count    = 0;
		mismatch_count = 0;
		other_errors   = 0;
		records        = 0;
		reset_n        = 1'b0;
		cpu_clken      = 1'b0;
		phi0           = 1'b1;
		model          = 1'b0;
		cpu            = '{addr: 16'h0000, wdata: 8'h00, r_nw: 1'b1, sync: 1'b0};
		crtc           = '0;
		via_pb         = 8'h00;
		mem_di         = 8'h00;

		@(negedge CLK48M_I);
		apply_reset();

		fd = $fopen(PATTERN_FILE, "r");
		if (fd == 0) begin
			other_errors++;
			$display("Could not open the pattern file %s", PATTERN_FILE);
		end else begin
			while (!$feof(fd) && records < MAX_RECORDS) begin
				code = $fgets(line, fd);
				if (code == 0) begin
					break;
				end
				if (line.len() < 2 || line.getc(0) == "#") begin
					continue;
				end
				fields = $sscanf(line, "%c %h %h %h %h %h %h %h",
					op, f_model, f_phi0, f_addr, f_data, e1, e2, e3);
				if (fields != 8) begin
					other_errors++;
					$display("Malformed pattern line: %s", line);
				end else begin
					run_record(op, f_model, f_phi0, f_addr, f_data, e1, e2, e3);
					records++;
				end
			end
			$fclose(fd);
			if (records == 0) begin
				other_errors++;
				$display("No pattern records were read from %s", PATTERN_FILE);
			end
		end

		$display("Records: %0d, checks: %0d, mismatches: %0d, other errors: %0d",
			records, check_count, mismatch_count, other_errors);
		if (mismatch_count == 0 && other_errors == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* bench/bbc_glue_chk.sv */
`timescale 1ns/1ps
`default_nettype none

module bbc_glue_chk (
	input logic                   CLK48M_I,
	input logic                   reset_n,
	input logic                   cpu_clken_i,
	input logic                   model_i,
	input logic                   phi0_i,
	input bbc_glue_pkg::cpu_bus_t cpu_i,
	input bbc_glue_pkg::dev_sel_t sel_i,
	input logic [7:0]             romsel_i,
	input bbc_glue_pkg::acccon_t  acccon_i,
	input bbc_glue_pkg::ic32_t    ic32_i,
	input logic                   vdu_op_i,
	input logic [15:0]            mem_adr_i,
	input logic                   mem_we_i
);

	import bbc_glue_pkg::*;

	// CPU writes memory only in its own half cycle and at its own address
	we_in_phi0: assert property (@(posedge CLK48M_I)
		mem_we_i |-> (phi0_i && mem_adr_i == cpu_i.addr))
		else $error("mem_we active outside the CPU half cycle");

	region_onehot: assert property (@(posedge CLK48M_I)
		$onehot0({sel_i.ram, sel_i.rom, sel_i.mos, sel_i.fred, sel_i.jim, sel_i.sheila}))
		else $error("more than one memory region selected");

	romsel_b_bit7: assert property (@(posedge CLK48M_I) disable iff (!reset_n)
		(cpu_clken_i && !cpu_i.r_nw && sel_i.romsel && !model_i) |=> !romsel_i[7])
		else $error("romsel bit 7 set after a Model B write");

	regs_cleared: assert property (@(posedge CLK48M_I)
		!reset_n |=> (romsel_i == 8'h00 && acccon_i == 8'h00 && ic32_i == 8'h00 && !vdu_op_i))
		else $error("registers not cleared by reset");

endmodule

bind bbc_glue bbc_glue_chk u_bbc_glue_chk (
	.CLK48M_I    (CLK48M_I),
	.reset_n     (reset_n),
	.cpu_clken_i (cpu_clken_i),
	.model_i     (model_i),
	.phi0_i      (phi0_i),
	.cpu_i       (cpu_i),
	.sel_i       (sel),
	.romsel_i    (romsel),
	.acccon_i    (acccon),
	.ic32_i      (ic32),
	.vdu_op_i    (vdu_op),
	.mem_adr_i   (mem_adr_o),
	.mem_we_i    (mem_we_o)
);

`default_nettype wire

/* design/bbc_glue.sv */
`timescale 1ns/1ps
`default_nettype none

module bbc_glue (
	input  logic                     CLK48M_I,
	input  logic                     reset_n,
	input  logic                     cpu_clken_i,
	input  logic                     phi0_i,
	input  logic                     model_i,
	input  bbc_glue_pkg::cpu_bus_t   cpu_i,
	input  bbc_glue_pkg::crtc_addr_t crtc_i,
	input  logic [7:0]               via_pb_i,
	input  logic [7:0]               mem_di_i,
	output logic [7:0]               cpu_di_o,
	output bbc_glue_pkg::dev_sel_t   sel_o,
	output logic [7:0]               romsel_o,
	output bbc_glue_pkg::acccon_t    acccon_o,
	output bbc_glue_pkg::ic32_t      ic32_o,
	output logic                     shadow_ram_o,
	output logic                     shadow_vid_o,
	output logic                     irq_o,
	output logic [15:0]              mem_adr_o,
	output logic                     mem_we_o
);

	import bbc_glue_pkg::*;

	dev_sel_t          sel;
	logic [7:0]        romsel;
	acccon_t           acccon;
	ic32_t             ic32;
	logic              vdu_op;
	logic [DISP_W-1:0] disp_a;

	address_decode u_address_decode (
		.addr_i  (cpu_i),
		.model_i (model_i),
		.sel_o   (sel)
	);

	system_latches u_system_latches (
		.CLK48M_I    (CLK48M_I),
		.reset_n     (reset_n),
		.cpu_clken_i (cpu_clken_i),
		.model_i     (model_i),
		.cpu_i       (cpu_i),
		.sel_i       (sel),
		.via_pb_i    (via_pb_i),
		.romsel_o    (romsel),
		.acccon_o    (acccon),
		.ic32_o      (ic32),
		.vdu_op_o    (vdu_op)
	);

	display_addr_xlate u_display_addr_xlate (
		.crtc_i   (crtc_i),
		.mode_i   (ic32.disp_addr_offs),
		.disp_a_o (disp_a)
	);

	bus_result u_bus_result (
		.model_i      (model_i),
		.phi0_i       (phi0_i),
		.cpu_i        (cpu_i),
		.sel_i        (sel),
		.romsel_i     (romsel),
		.acccon_i     (acccon),
		.vdu_op_i     (vdu_op),
		.disp_a_i     (disp_a),
		.mem_di_i     (mem_di_i),
		.cpu_di_o     (cpu_di_o),
		.shadow_ram_o (shadow_ram_o),
		.mem_adr_o    (mem_adr_o),
		.mem_we_o     (mem_we_o)
	);

	assign sel_o        = sel;
	assign romsel_o     = romsel;
	assign acccon_o     = acccon;
	assign ic32_o       = ic32;
	// Video fetches from shadow RAM
	assign shadow_vid_o = acccon.d;
	assign irq_o        = acccon.irr;

endmodule

`default_nettype wire

/* design/bus_result.sv */
`timescale 1ns/1ps
`default_nettype none

module bus_result (
	input  logic                            model_i,
	input  logic                            phi0_i,
	input  bbc_glue_pkg::cpu_bus_t          cpu_i,
	input  bbc_glue_pkg::dev_sel_t          sel_i,
	input  logic [7:0]                      romsel_i,
	input  bbc_glue_pkg::acccon_t           acccon_i,
	input  logic                            vdu_op_i,
	input  logic [bbc_glue_pkg::DISP_W-1:0] disp_a_i,
	input  logic [7:0]                      mem_di_i,
	output logic [7:0]                      cpu_di_o,
	output logic                            shadow_ram_o,
	output logic [15:0]                     mem_adr_o,
	output logic                            mem_we_o
);

	import bbc_glue_pkg::*;

	logic shadow_range;

	// CPU read data with undecoded locations reading as zero
	always_comb begin
		if (sel_i.ram || sel_i.rom || sel_i.mos) begin
			cpu_di_o = mem_di_i;
		end else if (sel_i.romsel && model_i) begin
			cpu_di_o = romsel_i;
		end else if (sel_i.acccon) begin
			cpu_di_o = acccon_i;
		end else begin
			cpu_di_o = 8'h00;
		end
	end

	// Shadow window 0x3000-0x7FFF
	assign shadow_range = (cpu_i.addr[15:12] == 4'h3) || (cpu_i.addr[15:14] == 2'b01);

	// X maps all accesses, E only those made by VDU driver code
	assign shadow_ram_o = shadow_range &&
		(acccon_i.x || (acccon_i.e && vdu_op_i && !cpu_i.sync));

	// CPU owns memory in PHI0 high, video otherwise
	assign mem_adr_o = phi0_i ? cpu_i.addr : {1'b0, disp_a_i};
	assign mem_we_o  = phi0_i && !cpu_i.r_nw;

endmodule

`default_nettype wire

/* design/display_addr_xlate.sv */
`timescale 1ns/1ps
`default_nettype none

module display_addr_xlate (
	input  bbc_glue_pkg::crtc_addr_t            crtc_i,
	input  bbc_glue_pkg::disp_mode_e            mode_i,
	output logic [bbc_glue_pkg::DISP_W-1:0]     disp_a_o
);

	import bbc_glue_pkg::*;

	logic [3:0] wrap_add;
	logic [3:0] hi_nib;

	// Offset that folds the 0x8000 wrap back to the screen start
	always_comb begin
		case (mode_i)
			MODE_3:   wrap_add = 4'd8;
			MODE_6:   wrap_add = 4'd12;
			MODE_012: wrap_add = 4'd6;
			MODE_45:  wrap_add = 4'd11;
			default:  wrap_add = 4'd0;
		endcase
	end

	// Adjust only once MA has run past the top of memory
	assign hi_nib = crtc_i.ma[12] ? (crtc_i.ma[11:8] + wrap_add) : crtc_i.ma[11:8];

	always_comb begin
		if (crtc_i.ma[13]) begin
			// Teletext character codes sit at 0x7C00 upward
			disp_a_o = {hi_nib[3], 4'b1111, crtc_i.ma[9:0]};
		end else begin
			// Bitmap modes use eight rows per character cell
			disp_a_o = {hi_nib, crtc_i.ma[7:0], crtc_i.ra[2:0]};
		end
	end

endmodule

`default_nettype wire

/* design/system_latches.sv */
`timescale 1ns/1ps
`default_nettype none

module system_latches (
	input  logic                   CLK48M_I,
	input  logic                   reset_n,
	input  logic                   cpu_clken_i,
	input  logic                   model_i,
	input  bbc_glue_pkg::cpu_bus_t cpu_i,
	input  bbc_glue_pkg::dev_sel_t sel_i,
	input  logic [7:0]             via_pb_i,
	output logic [7:0]             romsel_o,
	output bbc_glue_pkg::acccon_t  acccon_o,
	output bbc_glue_pkg::ic32_t    ic32_o,
	output logic                   vdu_op_o
);

	import bbc_glue_pkg::*;

	logic [7:0] romsel_q;
	acccon_t    acccon_q;
	logic [7:0] ic32_q;
	logic       vdu_op_q;
	logic       cpu_wr;

	// Register writes only in the CPU cycle
	assign cpu_wr = cpu_clken_i && !cpu_i.r_nw;

	// ROM select latch
	always_ff @(posedge CLK48M_I) begin
		if (!reset_n) begin
			romsel_q <= '0;
		end else if (cpu_wr && sel_i.romsel) begin
			// Model B has no bit 7 on the latch
			romsel_q <= {model_i & cpu_i.wdata[7], cpu_i.wdata[6:0]};
		end
	end

	// Access control register exists only in the Master decode
	always_ff @(posedge CLK48M_I) begin
		if (!reset_n) begin
			acccon_q <= '0;
		end else if (cpu_wr && sel_i.acccon) begin
			acccon_q <= acccon_t'(cpu_i.wdata);
		end
	end

	// Remember where the last opcode came from
	always_ff @(posedge CLK48M_I) begin
		if (!reset_n) begin
			vdu_op_q <= 1'b0;
		end else if (cpu_clken_i && cpu_i.sync) begin
			vdu_op_q <= (cpu_i.addr[15:13] == VDU_OP_TOP);
		end
	end

	// IC32 addressable latch where PB2:0 select the bit and PB3 gives the value
	always_ff @(posedge CLK48M_I) begin
		if (!reset_n) begin
			ic32_q <= '0;
		end else begin
			ic32_q[via_pb_i[2:0]] <= via_pb_i[3];
		end
	end

	assign romsel_o = romsel_q;
	assign acccon_o = acccon_q;
	assign ic32_o   = ic32_t'(ic32_q);
	assign vdu_op_o = vdu_op_q;

endmodule

`default_nettype wire

/* design/address_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module address_decode (
	input  bbc_glue_pkg::cpu_bus_t addr_i,
	input  logic                   model_i,
	output bbc_glue_pkg::dev_sel_t sel_o
);

	import bbc_glue_pkg::*;

	logic [15:0] a;
	logic [7:0]  page;
	logic        io_page;
	logic        romsel_b;
	logic        romsel_m;

	assign a    = addr_i.addr;
	assign page = a[15:8];

	assign io_page = (page == PAGE_FRED) || (page == PAGE_JIM) || (page == PAGE_SHEILA);

	// Model B mirrors ROMSEL over FE30-FE3F, Master only FE30-FE33
	assign romsel_b = (a[7:4] == 4'h3);
	assign romsel_m = (a[7:2] == 6'b0011_00);

	always_comb begin
		sel_o = '0;

		// Memory regions
		sel_o.ram = ~a[15];
		sel_o.rom = (a[15:14] == 2'b10);
		// Page FF belongs to the MOS ROM
		sel_o.mos = (a[15:14] == 2'b11) && !io_page;

		sel_o.fred   = (page == PAGE_FRED);
		sel_o.jim    = (page == PAGE_JIM);
		sel_o.sheila = (page == PAGE_SHEILA);

		if (sel_o.sheila) begin
			sel_o.crtc     = (a[7:3] == 5'b0_0000);
			sel_o.romsel   = model_i ? romsel_m : romsel_b;
			sel_o.acccon   = model_i && (a[7:2] == 6'b0011_01);
			sel_o.sys_via  = (a[7:5] == 3'b010);
			sel_o.user_via = (a[7:5] == 3'b011);
		end
	end

endmodule

`default_nettype wire

/* design/bbc_glue_pkg.sv */
`default_nettype none

package bbc_glue_pkg;

	// 6502 bus as seen by the glue logic
	typedef struct packed {
		logic [15:0] addr;
		logic [7:0]  wdata;
		logic        r_nw;
		logic        sync;
	} cpu_bus_t;

	// Region and device selects
	typedef struct packed {
		logic ram;
		logic rom;
		logic mos;
		logic fred;
		logic jim;
		logic sheila;
		logic crtc;
		logic romsel;
		logic acccon;
		logic sys_via;
		logic user_via;
	} dev_sel_t;

	// Master access control register at 0xFE34
	typedef struct packed {
		logic irr;
		logic tst;
		logic ifj;
		logic itu;
		logic y;
		logic x;
		logic e;
		logic d;
	} acccon_t;

	// Screen wrap modes held in IC32 bits 5:4
	typedef enum logic [1:0] {
		MODE_3   = 2'd0,
		MODE_6   = 2'd1,
		MODE_012 = 2'd2,
		MODE_45  = 2'd3
	} disp_mode_e;

	// Addressable latch IC32
	typedef struct packed {
		logic       shift_lock_led_n;
		logic       caps_lock_led_n;
		disp_mode_e disp_addr_offs;
		logic       keyb_enable_n;
		logic       speech_read_n;
		logic       speech_write_n;
		logic       sound_enable_n;
	} ic32_t;

	// 6845 refresh address and raster row
	typedef struct packed {
		logic [13:0] ma;
		logic [4:0]  ra;
	} crtc_addr_t;

	// IO pages
	localparam logic [7:0] PAGE_FRED   = 8'hFC;
	localparam logic [7:0] PAGE_JIM    = 8'hFD;
	localparam logic [7:0] PAGE_SHEILA = 8'hFE;

	// Opcode fetch from 0xC000-0xDFFF marks a VDU driver op
	localparam logic [2:0] VDU_OP_TOP = 3'b110;

	localparam int DISP_W = 15;

endpackage

`default_nettype wire
